/* all.f */
+incdir+include
design/cnn_cmd_pkg.sv
design/cnn_data_pkg.sv
design/cnn_cmd_decoder.sv
design/cnn_kernel.sv
design/cnn_result_stage.sv
design/cnn_core_top.sv
dv/cnn_core_sva.sv
dv/cnn_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CNN core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cnn_core_tb -f all.f -o cnn_core_sim

./obj_dir/cnn_core_sim

/* dv/cnn_core_tb.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_core_tb;

    localparam int RESET_CYCLES = 16;
    localparam int LOAD_CONVS   = 40;
    localparam int STREAM_CMDS  = 400;
    localparam int IGNORE_CMDS  = 200;
    // About 700 commands plus reset and drain with a wide margin
    localparam int MAX_CYCLES   = 2000;
    localparam int LATENCY      = `KERNEL_LAT + 2;

    logic                  clk;
    logic                  reset_n;
    logic                  i_cmd_valid;
    cnn_cmd_pkg::cmd_t     i_cmd;
    logic                  o_result_valid;
    cnn_data_pkg::result_t o_result;

    // Shadow filter store
    logic [`CI*`W_BW-1:0]       shadow_w [`NUM_FILTERS];
    logic signed [`BIAS_BW-1:0] shadow_b [`NUM_FILTERS];

    cnn_data_pkg::result_t exp_q [$];
    int                    due_q [$];
    string                 name_q [$];

    logic [31:0] lfsr = 32'h510c0469;
    int          cycle = 0;
    string       test_name;

    cnn_core_top dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_cmd_valid    (i_cmd_valid),
        .i_cmd          (i_cmd),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Dot product, bias, optional ReLU, clamp
    function automatic cnn_data_pkg::result_t expected_result(
        input logic [`FILT_BW-1:0]        filt,
        input logic [`CI*`OF_BW-1:0]      pixels,
        input logic [`CI*`W_BW-1:0]       weights,
        input logic signed [`BIAS_BW-1:0] bias,
        input logic                       relu
    );
        cnn_data_pkg::result_t r;
        longint                acc;
        longint                max_v;
        longint                min_v;
        acc = 0;
        for (int c = 0; c < `CI; c++) begin
            acc += longint'(pixels[c*`OF_BW +: `OF_BW]) *
                   longint'($signed(weights[c*`W_BW +: `W_BW]));
        end
        acc += longint'(bias);
        if (relu && acc < 0) begin
            acc = 0;
        end
        max_v  = (longint'(1) << (`OUT_BW - 1)) - 1;
        min_v  = -(longint'(1) << (`OUT_BW - 1));
        r.filt = filt;
        r.sat  = (acc > max_v) || (acc < min_v);
        if (acc > max_v) begin
            acc = max_v;
        end else if (acc < min_v) begin
            acc = min_v;
        end
        r.value = acc[`OUT_BW-1:0];
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_result(input string name, input cnn_data_pkg::result_t exp_res,
                                input cnn_data_pkg::result_t act);
        if (act !== exp_res) begin
            abort_run($sformatf(
                "[FAIL] %s expected filt=%0d value=%0d sat=%0b actual filt=%0d value=%0d sat=%0b",
                name, exp_res.filt, exp_res.value, exp_res.sat, act.filt, act.value, act.sat));
        end
    endtask

    // Drive one command and update the model at the same time
    task automatic send_cmd(input logic [2:0] code, input logic [`FILT_BW-1:0] filt,
                            input logic [`CI*`OF_BW-1:0] data);
        cnn_cmd_pkg::cmd_t c;
        c.opcode = cnn_cmd_pkg::opcode_e'(code);
        c.filt   = filt;
        c.data   = data;
        @(posedge clk);
        #1;
        i_cmd_valid = 1'b1;
        i_cmd       = c;
        case (c.opcode)
            cnn_cmd_pkg::OP_LOAD_WEIGHT: shadow_w[filt] = data[`CI*`W_BW-1:0];
            cnn_cmd_pkg::OP_LOAD_BIAS:   shadow_b[filt] = data[`BIAS_BW-1:0];
            cnn_cmd_pkg::OP_CONV, cnn_cmd_pkg::OP_CONV_RELU: begin
                exp_q.push_back(expected_result(filt, data, shadow_w[filt], shadow_b[filt],
                                                c.opcode == cnn_cmd_pkg::OP_CONV_RELU));
                due_q.push_back(cycle + LATENCY);
                name_q.push_back(test_name);
            end
            default: begin
            end
        endcase
    endtask

    // Command bits stay random while valid is low
    task automatic idle_cycles(input int n);
        cnn_cmd_pkg::cmd_t c;
        repeat (n) begin
            c.opcode = cnn_cmd_pkg::opcode_e'(3'(rand_bits(3)));
            c.filt   = `FILT_BW'(rand_bits(2));
            c.data   = 24'(rand_bits(24));
            @(posedge clk);
            #1;
            i_cmd_valid = 1'b0;
            i_cmd       = c;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare process and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        cnn_data_pkg::result_t exp_res;
        string                 name;
        int                    due;
        if (reset_n && o_result_valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Result at cycle %0d with no CONV waiting for it", cycle));
            end else begin
                exp_res = exp_q.pop_front();
                name    = name_q.pop_front();
                due     = due_q.pop_front();
                if (cycle != due) begin
                    abort_run($sformatf("In %s a result came at cycle %0d, due at cycle %0d",
                                        name, cycle, due));
                end else begin
                    check_result(name, exp_res, o_result);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [2:0]            code;
        logic [`CI*`OF_BW-1:0] pix;
        reset_n     = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        for (int f = 0; f < `NUM_FILTERS; f++) begin
            shadow_w[f] = '0;
            shadow_b[f] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b1;

        // Filters read as zero after reset
        test_name = "reset_zero";
        idle_cycles(8);
        for (int f = 0; f < `NUM_FILTERS; f++) begin
            send_cmd(cnn_cmd_pkg::OP_CONV, `FILT_BW'(f), 24'(rand_bits(24)));
            send_cmd(cnn_cmd_pkg::OP_CONV_RELU, `FILT_BW'(f), 24'(rand_bits(24)));
        end
        idle_cycles(4);

        test_name = "load_filters";
        for (int f = 0; f < `NUM_FILTERS; f++) begin
            send_cmd(cnn_cmd_pkg::OP_LOAD_WEIGHT, `FILT_BW'(f), 24'(rand_bits(24)));
            send_cmd(cnn_cmd_pkg::OP_LOAD_BIAS, `FILT_BW'(f), 24'(rand_bits(24)));
        end
        for (int i = 0; i < LOAD_CONVS; i++) begin
            send_cmd(cnn_cmd_pkg::OP_CONV, `FILT_BW'(rand_bits(2)), 24'(rand_bits(24)));
        end
        idle_cycles(4);

        // One command per cycle with loads mixed in
        test_name = "back_to_back";
        for (int i = 0; i < STREAM_CMDS; i++) begin
            code = 3'(rand_bits(3));
            if (code == 3'd0) begin
                code = cnn_cmd_pkg::OP_LOAD_WEIGHT;
            end else if (code == 3'd1) begin
                code = cnn_cmd_pkg::OP_LOAD_BIAS;
            end else begin
                code = code[0] ? cnn_cmd_pkg::OP_CONV_RELU : cnn_cmd_pkg::OP_CONV;
            end
            send_cmd(code, `FILT_BW'(rand_bits(2)), 24'(rand_bits(24)));
        end
        idle_cycles(4);

        // Negative weights and bias with and without ReLU
        test_name = "relu_signed";
        send_cmd(cnn_cmd_pkg::OP_LOAD_WEIGHT, 2'd1, 24'h80E0F0);
        send_cmd(cnn_cmd_pkg::OP_LOAD_BIAS, 2'd1, 24'h00FF9C);
        for (int i = 0; i < 5; i++) begin
            pix = 24'(rand_bits(24)) | 24'h010101;
            send_cmd(cnn_cmd_pkg::OP_CONV, 2'd1, pix);
            send_cmd(cnn_cmd_pkg::OP_CONV_RELU, 2'd1, pix);
        end
        idle_cycles(4);

        test_name = "saturation";
        send_cmd(cnn_cmd_pkg::OP_LOAD_WEIGHT, 2'd2, 24'h7F7F7F);
        send_cmd(cnn_cmd_pkg::OP_LOAD_BIAS, 2'd2, 24'h007FFF);
        send_cmd(cnn_cmd_pkg::OP_LOAD_WEIGHT, 2'd3, 24'h808080);
        send_cmd(cnn_cmd_pkg::OP_LOAD_BIAS, 2'd3, 24'h008000);
        send_cmd(cnn_cmd_pkg::OP_CONV, 2'd2, 24'hFFFFFF);
        send_cmd(cnn_cmd_pkg::OP_CONV, 2'd3, 24'hFFFFFF);
        send_cmd(cnn_cmd_pkg::OP_CONV_RELU, 2'd3, 24'hFFFFFF);
        send_cmd(cnn_cmd_pkg::OP_LOAD_BIAS, 2'd3, 24'h000000);
        send_cmd(cnn_cmd_pkg::OP_CONV, 2'd3, 24'hFFFFFF);
        idle_cycles(4);

        // NOP and codes 5 to 7 among CONVs
        test_name = "ignored_cmds";
        for (int i = 0; i < IGNORE_CMDS; i++) begin
            code = 3'(rand_bits(3));
            if (code == 3'd1 || code == 3'd2) begin
                code = cnn_cmd_pkg::OP_NOP;
            end
            send_cmd(code, `FILT_BW'(rand_bits(2)), 24'(rand_bits(24)));
        end

        idle_cycles(LATENCY + 6);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never came out", exp_q.size()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* dv/cnn_core_sva.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_core_sva (
    input logic              clk,
    input logic              reset_n,
    input logic              i_cmd_valid,
    input cnn_cmd_pkg::cmd_t i_cmd,
    input logic              req_valid,
    input logic              kout_valid,
    input logic              o_result_valid
);

    // Decoder, kernel and result stage
    localparam int LAT = `KERNEL_LAT + 2;

    logic conv_cmd;

    assign conv_cmd = i_cmd_valid && (i_cmd.opcode == cnn_cmd_pkg::OP_CONV ||
                                      i_cmd.opcode == cnn_cmd_pkg::OP_CONV_RELU);

    a_reset_quiet: assert property (@(posedge clk)
        !reset_n |-> !req_valid && !kout_valid && !o_result_valid)
        else $error("Pipeline valid high while reset is held");

    a_conv_gives_result: assert property (@(posedge clk) disable iff (!reset_n)
        $past(conv_cmd, LAT) |-> o_result_valid)
        else $error("CONV command not followed by o_result_valid after %0d cycles", LAT);

    a_result_needs_conv: assert property (@(posedge clk) disable iff (!reset_n)
        o_result_valid |-> $past(conv_cmd, LAT))
        else $error("o_result_valid without a CONV command %0d cycles earlier", LAT);

endmodule

bind cnn_core_top cnn_core_sva sva_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .req_valid      (req_valid),
    .kout_valid     (kout_valid),
    .o_result_valid (o_result_valid)
);

/* design/cnn_core_top.sv */
`timescale 1ns/1ps

module cnn_core_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  i_cmd_valid,
    input  cnn_cmd_pkg::cmd_t     i_cmd,
    output logic                  o_result_valid,
    output cnn_data_pkg::result_t o_result
);

    // Decoder to kernel
    logic                      req_valid;
    cnn_data_pkg::kernel_req_t req;

    // Kernel to result stage
    logic                      kout_valid;
    cnn_data_pkg::kernel_out_t kout;

    cnn_cmd_decoder u_decoder (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .o_req_valid (req_valid),
        .o_req       (req)
    );

    cnn_kernel u_kernel (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_out_valid (kout_valid),
        .o_out       (kout)
    );

    cnn_result_stage u_result (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_out_valid    (kout_valid),
        .i_out          (kout),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

endmodule

/* design/cnn_result_stage.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_result_stage (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_out_valid,
    input  cnn_data_pkg::kernel_out_t i_out,
    output logic                      o_result_valid,
    output cnn_data_pkg::result_t     o_result
);

    // One guard bit over the kernel sum for the bias add
    localparam int SUM_BW = `ACC_BW + 1;
    localparam logic signed [SUM_BW-1:0] OUT_MAX = SUM_BW'((1 << (`OUT_BW - 1)) - 1);
    // Bitwise inverse of the max gives the min
    localparam logic signed [SUM_BW-1:0] OUT_MIN = ~OUT_MAX;

    logic signed [SUM_BW-1:0]  biased;
    logic signed [SUM_BW-1:0]  rectified;
    logic signed [`OUT_BW-1:0] clamped;
    logic                      sat;

    ////////////////////////////////////////////////////////////////////////////
    // Bias, ReLU, saturation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        biased = SUM_BW'(i_out.sum) + SUM_BW'(i_out.tag.bias);

        if (i_out.tag.relu && biased < 0) begin
            rectified = '0;
        end else begin
            rectified = biased;
        end

        // Flag only when the clamp changes the value
        if (rectified > OUT_MAX) begin
            clamped = OUT_MAX[`OUT_BW-1:0];
            sat     = 1'b1;
        end else if (rectified < OUT_MIN) begin
            clamped = OUT_MIN[`OUT_BW-1:0];
            sat     = 1'b1;
        end else begin
            clamped = rectified[`OUT_BW-1:0];
            sat     = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_out_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_out_valid) begin
            o_result.filt  <= i_out.tag.filt;
            o_result.value <= clamped;
            o_result.sat   <= sat;
        end
    end

endmodule

/* design/cnn_kernel.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_kernel (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_req_valid,
    input  cnn_data_pkg::kernel_req_t i_req,
    output logic                      o_out_valid,
    output cnn_data_pkg::kernel_out_t o_out
);

    localparam int LATENCY = `KERNEL_LAT;

    // One bit per pipeline stage
    logic [LATENCY-1:0]        valid_sr;
    logic signed [`MUL_BW-1:0] mul   [`CI];
    logic signed [`MUL_BW-1:0] mul_q [`CI];
    logic signed [`ACC_BW-1:0] acc;
    cnn_data_pkg::tag_t        tag_q;
    cnn_data_pkg::kernel_out_t out_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LATENCY-2:0], i_req_valid};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, per-channel multiply
    ////////////////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < `CI; c++) begin : g_mul
        logic signed [`MUL_BW-1:0] pix_ext;
        logic signed [`MUL_BW-1:0] wgt_ext;

        // Pixel is zero extended, weight sign extended
        assign pix_ext = `MUL_BW'(i_req.pixels[c*`OF_BW +: `OF_BW]);
        assign wgt_ext = `MUL_BW'($signed(i_req.weights[c*`W_BW +: `W_BW]));
        assign mul[c]  = pix_ext * wgt_ext;
    end

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            for (int c = 0; c < `CI; c++) begin
                mul_q[c] <= mul[c];
            end
            tag_q <= i_req.tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, channel sum
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        acc = '0;
        for (int c = 0; c < `CI; c++) begin
            acc = acc + `ACC_BW'(mul_q[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (valid_sr[0]) begin
            out_q.sum <= acc;
            out_q.tag <= tag_q;
        end
    end

    assign o_out_valid = valid_sr[LATENCY-1];
    assign o_out       = out_q;

endmodule

/* design/cnn_cmd_decoder.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_cmd_decoder (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_cmd_valid,
    input  cnn_cmd_pkg::cmd_t         i_cmd,
    output logic                      o_req_valid,
    output cnn_data_pkg::kernel_req_t o_req
);

    // Filter store, one entry per filter
    logic [`CI*`W_BW-1:0]       weight_q [`NUM_FILTERS];
    logic signed [`BIAS_BW-1:0] bias_q   [`NUM_FILTERS];

    logic load_w;
    logic load_b;
    logic conv;
    logic relu;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        load_w = 1'b0;
        load_b = 1'b0;
        conv   = 1'b0;
        relu   = 1'b0;
        case (i_cmd.opcode)
            cnn_cmd_pkg::OP_LOAD_WEIGHT: load_w = i_cmd_valid;
            cnn_cmd_pkg::OP_LOAD_BIAS:   load_b = i_cmd_valid;
            cnn_cmd_pkg::OP_CONV:        conv   = i_cmd_valid;
            cnn_cmd_pkg::OP_CONV_RELU: begin
                conv = i_cmd_valid;
                relu = 1'b1;
            end
            // NOP and undefined codes
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Weight and bias registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int f = 0; f < `NUM_FILTERS; f++) begin
                weight_q[f] <= '0;
                bias_q[f]   <= '0;
            end
        end else if (load_w) begin
            weight_q[i_cmd.filt] <= i_cmd.data[`CI*`W_BW-1:0];
        end else if (load_b) begin
            bias_q[i_cmd.filt] <= i_cmd.data[`BIAS_BW-1:0];
        end
    end

    // Request strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= conv;
        end
    end

    // Store read happens before any write at this edge
    always_ff @(posedge clk) begin
        if (conv) begin
            o_req.pixels   <= i_cmd.data;
            o_req.weights  <= weight_q[i_cmd.filt];
            o_req.tag.filt <= i_cmd.filt;
            o_req.tag.relu <= relu;
            o_req.tag.bias <= bias_q[i_cmd.filt];
        end
    end

endmodule

/* design/cnn_data_pkg.sv */
`include "cnn_config.svh"

package cnn_data_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Internal datapath types
    ////////////////////////////////////////////////////////////////////////////

    // Travels beside the data through the kernel
    typedef struct packed {
        logic [`FILT_BW-1:0]        filt;
        logic                       relu;
        logic signed [`BIAS_BW-1:0] bias;
    } tag_t;

    // Decoder to kernel
    typedef struct packed {
        logic [`CI*`OF_BW-1:0] pixels;
        logic [`CI*`W_BW-1:0]  weights;
        tag_t                  tag;
    } kernel_req_t;

    // Kernel to result stage
    typedef struct packed {
        logic signed [`ACC_BW-1:0] sum;
        tag_t                      tag;
    } kernel_out_t;

    // Final output
    typedef struct packed {
        logic [`FILT_BW-1:0]       filt;
        logic signed [`OUT_BW-1:0] value;
        logic                      sat;
    } result_t;

endpackage

/* design/cnn_cmd_pkg.sv */
`include "cnn_config.svh"

package cnn_cmd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Command port types
    ////////////////////////////////////////////////////////////////////////////

    // Codes 5 to 7 are not defined
    typedef enum logic [2:0] {
        OP_NOP         = 3'd0,
        OP_LOAD_WEIGHT = 3'd1,
        OP_LOAD_BIAS   = 3'd2,
        OP_CONV        = 3'd3,
        OP_CONV_RELU   = 3'd4
    } opcode_e;

    // Data field by opcode
    //   CONV / CONV_RELU  pixels, channel 0 in the low bits
    //   LOAD_WEIGHT       weights, channel 0 in the low bits
    //   LOAD_BIAS         bias in the low BIAS_BW bits
    typedef struct packed {
        opcode_e               opcode;
        logic [`FILT_BW-1:0]   filt;
        logic [`CI*`OF_BW-1:0] data;
    } cmd_t;

endpackage

/* include/cnn_config.svh */
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Input channels per pixel vector
`define CI          3

// Unsigned pixel and signed weight widths
`define OF_BW       8
`define W_BW        8

// Product holds 255 * -128 without overflow
`define MUL_BW      16
// Room for the channel sum
`define ACC_BW      (`MUL_BW + 2)

`define BIAS_BW     16
`define OUT_BW      16

// Filter store
`define NUM_FILTERS 4
`define FILT_BW     2

// Multiply stage plus sum stage
`define KERNEL_LAT  2

`endif
